// ==== multiplier_pkg.sv ====
package multiplier_pkg;

  // Operand width of the datapath.
  localparam int DATA_LENGTH = 64;

  // Partial-product chunks of operand b.
  localparam int NUM_MULS    = 4;
  localparam int CHUNK_WIDTH = DATA_LENGTH / NUM_MULS; // 16 bits per chunk.

  // Operand register, one stage per chunk, output register.
  localparam int MULTIPLIER_DEPTH = NUM_MULS + 2;

  // Load, two multipliers, quotient, difference and two corrections.
  localparam int PIPELINE_DEPTH = MULTIPLIER_DEPTH * 2 + 4;

  // Bit length of the modulus. Must hold 2k up to 126.
  localparam int BITLEN_WIDTH = 7;

  // Single-width operand.
  typedef logic [DATA_LENGTH-1:0] word_t;

  // Full product of two operands.
  typedef logic [2*DATA_LENGTH-1:0] dword_t;

  // Modulus bit length k.
  typedef logic [BITLEN_WIDTH-1:0] bitlen_t;

endpackage : multiplier_pkg

// ==== shiftreg.sv ====
`timescale 1ns/1ps

module shiftreg #(
  parameter int SHIFT = 1,
  parameter int DATA  = 64
) (
  input  logic            clk_i,
  input  logic [DATA-1:0] data_i,
  output logic [DATA-1:0] data_o
);

  logic [DATA-1:0] stage_q [SHIFT];

  // Payload only, so the chain carries no reset.
  always_ff @(posedge clk_i) begin
    stage_q[0] <= data_i;
    for (int i = 1; i < SHIFT; i++) begin
      stage_q[i] <= stage_q[i-1];
    end
  end

  assign data_o = stage_q[SHIFT-1]; // Oldest entry.

  // A zero-depth line would have no registers at all.
  initial begin
    assert (SHIFT >= 1)
      else $error("shiftreg: SHIFT must be at least 1, got %0d", SHIFT);
  end

endmodule : shiftreg

// ==== multiplier_top.sv ====
`timescale 1ns/1ps

module multiplier_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_i,
  input  multiplier_pkg::word_t  indata_a_i,
  input  multiplier_pkg::word_t  indata_b_i,
  output logic                   finish_o,
  output multiplier_pkg::dword_t outdata_r_o
);
  import multiplier_pkg::*;

  word_t  a_q   [NUM_MULS];     // Operand a per stage.
  word_t  b_q   [NUM_MULS];     // Operand b per stage.
  dword_t sum_q [1:NUM_MULS];   // Running sum of partial products.
  dword_t prod_q;
  logic [MULTIPLIER_DEPTH-1:0] fin_q;

  // Operand registers.
  always_ff @(posedge clk_i) begin
    a_q[0] <= indata_a_i;
    b_q[0] <= indata_b_i;
  end

  // One chunk of b per stage.
  for (genvar j = 0; j < NUM_MULS; j++) begin : g_stage
    logic [DATA_LENGTH+CHUNK_WIDTH-1:0] part;

    assign part = a_q[j] * b_q[j][j*CHUNK_WIDTH +: CHUNK_WIDTH];

    if (j == 0) begin : g_first
      always_ff @(posedge clk_i) begin
        sum_q[1] <= dword_t'(part); // Lowest chunk needs no shift.
      end
    end else begin : g_acc
      always_ff @(posedge clk_i) begin
        sum_q[j+1] <= sum_q[j] + (dword_t'(part) << (j * CHUNK_WIDTH));
      end
    end

    // Operands ride along until the last chunk.
    if (j < NUM_MULS - 1) begin : g_pass
      always_ff @(posedge clk_i) begin
        a_q[j+1] <= a_q[j];
        b_q[j+1] <= b_q[j];
      end
    end
  end

  // Output register.
  always_ff @(posedge clk_i) begin
    prod_q <= sum_q[NUM_MULS];
  end

  assign outdata_r_o = prod_q;

  // Start strobe follows the data through every stage.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fin_q <= '0;
    end else begin
      fin_q <= {fin_q[MULTIPLIER_DEPTH-2:0], start_i};
    end
  end

  assign finish_o = fin_q[MULTIPLIER_DEPTH-1];

  // No finish without a matching start, and the full product of its operands.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    finish_o |-> $past(start_i, MULTIPLIER_DEPTH) &&
      (outdata_r_o == dword_t'($past(indata_a_i, MULTIPLIER_DEPTH)) *
                      dword_t'($past(indata_b_i, MULTIPLIER_DEPTH))))
    else $error("multiplier_top: wrong finish or product at %0t", $time);

endmodule : multiplier_top

// ==== barrett_correct.sv ====
`timescale 1ns/1ps

module barrett_correct (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  valid_i,
  input  multiplier_pkg::word_t res_i,
  input  multiplier_pkg::word_t q_i,
  output multiplier_pkg::word_t result_o,
  output logic                  valid_o
);
  import multiplier_pkg::*;

  word_t res1_q;
  word_t q1_q, q2_q;
  logic  valid1_q;

  // Stage one, input below 3q leaves below 2q.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid1_q <= 1'b0;
      res1_q   <= '0;
    end else begin
      valid1_q <= valid_i;
      if (valid_i) res1_q <= (res_i >= q_i) ? res_i - q_i : res_i;
    end
  end

  // Stage two, now below q.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o  <= 1'b0;
      result_o <= '0;
    end else begin
      valid_o <= valid1_q;
      if (valid1_q) result_o <= (res1_q >= q1_q) ? res1_q - q1_q : res1_q;
    end
  end

  // Modulus follows its value.
  always_ff @(posedge clk_i) begin
    if (valid_i)  q1_q <= q_i;
    if (valid1_q) q2_q <= q1_q;
  end

  // Two subtractions must be enough for every operation.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> (result_o < q2_q))
    else $error("barrett_correct: result %0d not below q %0d", result_o, q2_q);

endmodule : barrett_correct

// ==== barrett_pipelined.sv ====
`timescale 1ns/1ps

module barrett_pipelined (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  multiplier_pkg::word_t   x_i,      // Value to reduce.
  input  multiplier_pkg::word_t   q_i,      // Modulus.
  input  multiplier_pkg::word_t   mu_i,     // Floor of 2^(2k) / q.
  input  multiplier_pkg::bitlen_t q_bl_i,   // Bit length k of q.
  output multiplier_pkg::word_t   result_o, // x mod q.
  output logic                    valid_o
);
  import multiplier_pkg::*;

  // Start strobe, index n is high after edge n-1.
  logic [PIPELINE_DEPTH-1:1] start_q;

  word_t   x_reg, q_reg, mu_reg;
  bitlen_t k_reg;

  word_t   x_d;      // x beside both multipliers.
  word_t   q_d1;     // q at the second multiplier.
  word_t   q_d2;     // q at the correction.
  bitlen_t k_d;      // k at the quotient stage.

  dword_t  xmu_prod;
  dword_t  qm_prod;
  word_t   q_hat;    // Quotient estimate.
  word_t   diff_q;   // Remainder before correction.
  logic    precomp_finish;
  logic    approx_finish;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= '0;
    end else begin
      start_q <= {start_q[PIPELINE_DEPTH-2:1], start_i};
    end
  end

  // Load stage.
  always_ff @(posedge clk_i) begin
    x_reg  <= x_i;
    q_reg  <= q_i;
    mu_reg <= mu_i;
    k_reg  <= q_bl_i;
  end

  shiftreg #(
    .SHIFT(2 * MULTIPLIER_DEPTH + 2),
    .DATA (DATA_LENGTH)
  ) shift_x (
    .clk_i (clk_i),
    .data_i(x_i),
    .data_o(x_d)
  );

  shiftreg #(
    .SHIFT(MULTIPLIER_DEPTH),
    .DATA (BITLEN_WIDTH)
  ) shift_k (
    .clk_i (clk_i),
    .data_i(k_reg),
    .data_o(k_d)
  );

  shiftreg #(
    .SHIFT(MULTIPLIER_DEPTH + 1),
    .DATA (DATA_LENGTH)
  ) shift_q1 (
    .clk_i (clk_i),
    .data_i(q_reg),
    .data_o(q_d1)
  );

  shiftreg #(
    .SHIFT(MULTIPLIER_DEPTH + 1),
    .DATA (DATA_LENGTH)
  ) shift_q2 (
    .clk_i (clk_i),
    .data_i(q_d1),
    .data_o(q_d2)
  );

  // x * mu.
  multiplier_top multiplier_precomp (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start_q[1]),
    .indata_a_i (x_reg),
    .indata_b_i (mu_reg),
    .finish_o   (precomp_finish),
    .outdata_r_o(xmu_prod)
  );

  // Quotient estimate, (x * mu) >> 2k.
  always_ff @(posedge clk_i) begin
    if (start_q[MULTIPLIER_DEPTH+1]) q_hat <= word_t'(xmu_prod >> (2 * k_d));
  end

  // Estimate times q.
  multiplier_top multiplier_approx (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start_q[MULTIPLIER_DEPTH+2]),
    .indata_a_i (q_hat),
    .indata_b_i (q_d1),
    .finish_o   (approx_finish),
    .outdata_r_o(qm_prod)
  );

  // Difference stage, below 3q.
  always_ff @(posedge clk_i) begin
    if (start_q[2*MULTIPLIER_DEPTH+2]) diff_q <= x_d - word_t'(qm_prod);
  end

  barrett_correct correct_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (start_q[PIPELINE_DEPTH-1]),
    .res_i   (diff_q),
    .q_i     (q_d2),
    .result_o(result_o),
    .valid_o (valid_o)
  );

  // Both multipliers stay in step with the start chain.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (precomp_finish == start_q[MULTIPLIER_DEPTH+1]) &&
    (approx_finish == start_q[2*MULTIPLIER_DEPTH+2]))
    else $error("barrett_pipelined: multiplier finish out of step at %0t", $time);

endmodule : barrett_pipelined

// ==== tb_barrett_vectors.svh ====
`ifndef TB_BARRETT_VECTORS_SVH
`define TB_BARRETT_VECTORS_SVH

// Directed operations. Each row is {x, q, x mod q}, worked out by hand.
localparam int NUM_VECTORS = 14;

localparam logic [191:0] VECTORS [NUM_VECTORS] = '{
  {64'd0,                  64'd7,           64'd0},            // x is zero.
  {64'd5,                  64'd7,           64'd5},            // x below q.
  {64'd7,                  64'd7,           64'd0},            // x equals q.
  {64'd48,                 64'd7,           64'd6},            // x = q*q - 1.
  {64'd0,                  64'd1,           64'd0},            // Smallest modulus.
  {64'd6,                  64'd3,           64'd0},            // Estimate one short.
  {64'd20,                 64'd5,           64'd0},            // Estimate one short.
  {64'd72,                 64'd9,           64'd0},            // Estimate one short.
  {64'd3,                  64'd2,           64'd1},            // Estimate exact.
  {64'h3fff_ffff_0000_0000, 64'h7fff_ffff,  64'h7fff_fffe},    // Largest q, x = q*q - 1.
  {64'h1_8000_0002,        64'h7fff_ffff,   64'd5},            // Largest q, x = 3q + 5.
  {64'h7fff_ffff,          64'h7fff_ffff,   64'd0},            // Largest q, x = q.
  {64'h0fff_ffff_ffff_ffff, 64'h4000_0000,  64'h3fff_ffff},    // Power of two modulus.
  {64'h1_0002_0000,        64'h1_0001,      64'h1_0000}        // q = 65537, x = q*q - 1.
};

`endif

// ==== tb_barrett.sv ====
`timescale 1ns/1ps

module tb_barrett;
  import multiplier_pkg::*;

  localparam int LATENCY       = 16;  // Rising edges from start to valid.
  localparam int NUM_RANDOM    = 200;
  localparam int DRAIN_TIMEOUT = 100;

  `include "tb_barrett_vectors.svh"

  logic    clk_i, rst_ni, start_i, valid_o;
  word_t   x_i, q_i, mu_i, result_o;
  bitlen_t q_bl_i;

  integer  seed = 32'hb2b4_ff43;
  longint  cycle = 0;               // Rising edges seen so far.
  word_t   exp_q [$];               // Expected remainders, oldest first.
  longint  cyc_q [$];               // Edge count at issue time.
  word_t   mon_expect;
  longint  mon_cycle;
  int      issued, valids;
  int      value_errors, latency_errors, protocol_errors, timeouts;
  word_t   rx, rq;

  barrett_pipelined dut_i (
    .clk_i(clk_i), .rst_ni(rst_ni), .start_i(start_i), .x_i(x_i), .q_i(q_i),
    .mu_i(mu_i), .q_bl_i(q_bl_i), .result_o(result_o), .valid_o(valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle <= cycle + 1;

  function automatic bitlen_t bit_length(input word_t v);
    bitlen_t n;
    n = '0;
    for (int i = 0; i < DATA_LENGTH; i++) begin
      if (v[i]) n = bitlen_t'(i + 1);
    end
    return n;
  endfunction

  // Floor of 2^(2k) / q.
  function automatic word_t barrett_mu(input word_t q, input bitlen_t k);
    logic [127:0] num;
    num = 128'd1 << (2 * k);
    return word_t'(num / {64'd0, q});
  endfunction

  task automatic issue_op(input word_t x, input word_t q, input word_t rem);
    start_i = 1'b1;
    x_i     = x;
    q_i     = q;
    q_bl_i  = bit_length(q);
    mu_i    = barrett_mu(q, bit_length(q));
    exp_q.push_back(rem);
    cyc_q.push_back(cycle);
    issued++;
    @(negedge clk_i);
    start_i = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    start_i = 1'b0;
    repeat (n) @(negedge clk_i);
  endtask

  task automatic check_idle_outputs(input int n);
    repeat (n) begin
      @(negedge clk_i);
      if (valid_o !== 1'b0 || result_o !== '0) begin
        $display("ERROR at %0t: outputs not idle, valid_o=%b result_o=%0h",
                 $time, valid_o, result_o);
        protocol_errors++;
      end
    end
  endtask

  task automatic wait_drain(input string phase);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("Timed out with %0d results still outstanding after %s", exp_q.size(), phase);
      timeouts++;
    end
  endtask

  task automatic draw_operands(output word_t q, output word_t x);
    int unsigned shift;
    shift = $unsigned($random(seed)) % 31;  // Spread the bit lengths.
    q = word_t'($unsigned($random(seed)) & 32'h7fff_ffff) >> shift;
    if (q == 0) q = 1;
    x = {$random(seed), $random(seed)};
    x = x % (q * q);
  endtask

  // Scoreboard, sampled away from the rising edge.
  always @(negedge clk_i) begin
    if (rst_ni && valid_o) begin
      valids++;
      if (exp_q.size() == 0) begin
        $display("Unexpected valid_o at %0t with no operation outstanding", $time);
        protocol_errors++;
      end else begin
        mon_expect = exp_q.pop_front();
        mon_cycle  = cyc_q.pop_front();
        if (result_o !== mon_expect) begin
          $display("ERROR at %0t: result %0h, expected %0h", $time, result_o, mon_expect);
          value_errors++;
        end
        if (cycle - mon_cycle - 1 != LATENCY) begin
          $display("ERROR at %0t: valid_o came %0d edges after start, expected %0d",
                   $time, cycle - mon_cycle - 1, LATENCY);
          latency_errors++;
        end
      end
    end
  end

  initial begin
    rst_ni  = 1'b0;
    start_i = 1'b0;
    x_i     = '0;
    q_i     = '0;
    mu_i    = '0;
    q_bl_i  = '0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_idle_outputs(5);
    // Single operations with idle time between them.
    for (int i = 0; i < NUM_VECTORS; i++) begin
      issue_op(VECTORS[i][191:128], VECTORS[i][127:64], VECTORS[i][63:0]);
      wait_drain("a directed operation");
      idle_cycles(2);
    end
    // First half back to back, second half with random gaps.
    for (int i = 0; i < NUM_RANDOM; i++) begin
      if (i >= NUM_RANDOM / 2 && ($random(seed) & 1)) idle_cycles(1);
      draw_operands(rq, rx);
      issue_op(rx, rq, rx % rq);
    end
    wait_drain("the random stream");
    idle_cycles(LATENCY + 4);
    if (valids != issued) begin
      $display("Saw %0d valid pulses for %0d started operations", valids, issued);
      protocol_errors++;
    end
    $display("Errors: value %0d, latency %0d, protocol %0d, timeout %0d",
             value_errors, latency_errors, protocol_errors, timeouts);
    if (value_errors + latency_errors + protocol_errors + timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : tb_barrett

// ==== verilog.f ====
+incdir+.
multiplier_pkg.sv
shiftreg.sv
multiplier_top.sv
barrett_correct.sv
barrett_pipelined.sv
tb_barrett.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the Barrett reduction testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module tb_barrett -o tb_barrett
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_barrett)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q 'All tests passed!'; then
  exit 0
fi

echo "Simulation did not report a pass"
exit 1
